// ==== hdl/adapter_consts.svh ====
`ifndef ADAPTER_CONSTS_SVH
`define ADAPTER_CONSTS_SVH

// Feature word width in bits
`define ADAPTER_WORD_W 16

// Channel counts seen by the downstream stages
`define BN_IN_CHANNELS 16
`define FINAL_IN_CHANNELS 96

// Class scores produced by the final layer
`define NUM_CLASSES 15

// Buffer depths in words
`define ACC_FIFO_DEPTH 64
`define BN_FIFO_DEPTH 32

`endif

// ==== hdl/adapter_pkg.sv ====
`default_nettype none

`include "adapter_consts.svh"

package adapter_pkg;

    // One signed feature word
    typedef logic signed [`ADAPTER_WORD_W-1:0] word_t;

    // Beat into the bottleneck
    typedef struct packed {
        word_t                               data;
        logic [$clog2(`BN_IN_CHANNELS)-1:0]  channel; // Wraps at 16
    } bn_beat_t;

    // Beat into the final layer
    typedef struct packed {
        word_t                                  data;
        logic [$clog2(`FINAL_IN_CHANNELS)-1:0]  channel; // Wraps at 96
    } final_beat_t;

    // Class score vector, index 0 in the low word
    typedef word_t [`NUM_CLASSES-1:0] class_vec_t;

    // Frame phases of the sequencer
    typedef enum logic [2:0] {
        IDLE,
        ACC_RUN,    // First layer filling the acc FIFO
        ACC_DRAIN,  // Acc FIFO streaming into the bottleneck
        BN_RUN,     // Bottleneck filling the bn FIFO
        BN_DRAIN,   // Bn FIFO streaming into the final layer
        FINAL_RUN,  // Waiting on the class scores
        DONE
    } phase_t;

endpackage

`default_nettype wire

// ==== hdl/channel_feeder.sv ====
`default_nettype none

// Pops FIFO words into a registered beat tagged with a wrapping channel
module channel_feeder #(
    parameter type beat_t       = adapter_pkg::bn_beat_t,
    parameter int  NUM_CHANNELS = 16
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               run,
    input  wire logic               fifo_valid,
    input  wire adapter_pkg::word_t fifo_data,
    output logic                    fifo_ready,
    output logic                    beat_valid,
    output beat_t                   beat,
    input  wire logic               beat_ready,
    output logic                    drained
);

    localparam int CHAN_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;
    localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(NUM_CHANNELS - 1);

    logic [CHAN_W-1:0] chan_cnt;
    logic              pop;

    // Pop only when the beat register is free or leaving this cycle
    assign fifo_ready = run && (!beat_valid || beat_ready);
    assign pop        = fifo_valid && fifo_ready;

    assign drained = run && !fifo_valid && !beat_valid;

    always_ff @(posedge clk) begin
        if (pop) begin
            beat.data    <= fifo_data;
            beat.channel <= chan_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_valid <= 1'b0;
            chan_cnt   <= '0;
        end else begin
            if (pop) begin
                beat_valid <= 1'b1;
            end else if (beat_ready) begin
                beat_valid <= 1'b0; // Accepted with nothing behind it
            end

            // Counts across frames, cleared only by rst
            if (pop) begin
                chan_cnt <= (chan_cnt == LAST_CHAN) ? '0 : chan_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/feature_fifo.sv ====
`default_nettype none

// First-word-fall-through FIFO, head word visible while out_valid is high
module feature_fifo #(
    parameter int  DEPTH  = 16,
    parameter type item_t = logic [15:0]
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  in_valid,
    input  wire item_t in_data,
    output logic       in_ready,
    output logic       out_valid,
    output item_t      out_data,
    input  wire logic  out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    item_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != FULL_CNT);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap explicitly, depth need not be a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Idle or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/interface_adapter.sv ====
`default_nettype none

`include "adapter_consts.svh"

module interface_adapter (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    en,
    // First layer in
    input  wire logic                    acc_valid,
    input  wire adapter_pkg::word_t      acc_data,
    output logic                         acc_ready,
    input  wire logic                    acc_done,
    // Bottleneck
    output logic                         bn_in_valid,
    output adapter_pkg::bn_beat_t        bn_in_beat,
    input  wire logic                    bn_in_ready,
    input  wire logic                    bn_out_valid,
    input  wire adapter_pkg::word_t      bn_out_data,
    output logic                         bn_out_ready,
    input  wire logic                    bn_done,
    output logic                         bn_en,
    // Final layer
    output logic                         final_in_valid,
    output adapter_pkg::final_beat_t     final_in_beat,
    input  wire logic                    final_in_ready,
    input  wire logic                    final_out_valid,
    input  wire adapter_pkg::class_vec_t final_scores,
    output logic                         final_en,
    // Result
    output adapter_pkg::class_vec_t      scores,
    output logic                         scores_valid,
    output logic                         system_done
);

    logic acc_fill_en;
    logic acc_drain_en;
    logic bn_fill_en;
    logic bn_drain_en;
    logic acc_drained;
    logic bn_drained;

    logic               acc_push_valid;
    logic               acc_fifo_in_ready;
    logic               acc_fifo_valid;
    adapter_pkg::word_t acc_fifo_data;
    logic               acc_fifo_ready;

    logic               bn_push_valid;
    logic               bn_fifo_in_ready;
    logic               bn_fifo_valid;
    adapter_pkg::word_t bn_fifo_data;
    logic               bn_fifo_ready;

    // Fill side only open in its own phase
    assign acc_push_valid = acc_valid && acc_fill_en;
    assign acc_ready      = acc_fifo_in_ready && acc_fill_en;
    assign bn_push_valid  = bn_out_valid && bn_fill_en;
    assign bn_out_ready   = bn_fifo_in_ready && bn_fill_en;

    stage_sequencer seq (
        .clk, .rst, .en, .acc_done, .bn_done, .acc_drained, .bn_drained,
        .final_out_valid, .final_scores, .acc_fill_en, .acc_drain_en,
        .bn_fill_en, .bn_drain_en, .bn_en, .final_en, .scores, .scores_valid,
        .system_done
    );

    feature_fifo #(.DEPTH(`ACC_FIFO_DEPTH), .item_t(adapter_pkg::word_t)) acc_fifo (
        .clk, .rst,
        .in_valid (acc_push_valid), .in_data (acc_data), .in_ready (acc_fifo_in_ready),
        .out_valid (acc_fifo_valid), .out_data (acc_fifo_data), .out_ready (acc_fifo_ready)
    );

    channel_feeder #(
        .beat_t       (adapter_pkg::bn_beat_t),
        .NUM_CHANNELS (`BN_IN_CHANNELS)
    ) acc_feeder (
        .clk, .rst, .run (acc_drain_en),
        .fifo_valid (acc_fifo_valid), .fifo_data (acc_fifo_data), .fifo_ready (acc_fifo_ready),
        .beat_valid (bn_in_valid), .beat (bn_in_beat), .beat_ready (bn_in_ready),
        .drained (acc_drained)
    );

    feature_fifo #(.DEPTH(`BN_FIFO_DEPTH), .item_t(adapter_pkg::word_t)) bn_fifo (
        .clk, .rst,
        .in_valid (bn_push_valid), .in_data (bn_out_data), .in_ready (bn_fifo_in_ready),
        .out_valid (bn_fifo_valid), .out_data (bn_fifo_data), .out_ready (bn_fifo_ready)
    );

    channel_feeder #(
        .beat_t       (adapter_pkg::final_beat_t),
        .NUM_CHANNELS (`FINAL_IN_CHANNELS)
    ) bn_feeder (
        .clk, .rst, .run (bn_drain_en),
        .fifo_valid (bn_fifo_valid), .fifo_data (bn_fifo_data), .fifo_ready (bn_fifo_ready),
        .beat_valid (final_in_valid), .beat (final_in_beat), .beat_ready (final_in_ready),
        .drained (bn_drained)
    );

endmodule

`default_nettype wire

// ==== hdl/stage_sequencer.sv ====
`default_nettype none

// Frame phase FSM plus class score capture
module stage_sequencer (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    en,
    input  wire logic                    acc_done,
    input  wire logic                    bn_done,
    input  wire logic                    acc_drained,
    input  wire logic                    bn_drained,
    input  wire logic                    final_out_valid,
    input  wire adapter_pkg::class_vec_t final_scores,
    output logic                         acc_fill_en,
    output logic                         acc_drain_en,
    output logic                         bn_fill_en,
    output logic                         bn_drain_en,
    output logic                         bn_en,
    output logic                         final_en,
    output adapter_pkg::class_vec_t      scores,
    output logic                         scores_valid,
    output logic                         system_done
);

    adapter_pkg::phase_t phase;
    adapter_pkg::phase_t next_phase;
    logic                capture;

    always_comb begin
        next_phase = phase;
        case (phase)
            adapter_pkg::IDLE:      if (en)              next_phase = adapter_pkg::ACC_RUN;
            adapter_pkg::ACC_RUN:   if (acc_done)        next_phase = adapter_pkg::ACC_DRAIN;
            adapter_pkg::ACC_DRAIN: if (acc_drained)     next_phase = adapter_pkg::BN_RUN;
            adapter_pkg::BN_RUN:    if (bn_done)         next_phase = adapter_pkg::BN_DRAIN;
            adapter_pkg::BN_DRAIN:  if (bn_drained)      next_phase = adapter_pkg::FINAL_RUN;
            adapter_pkg::FINAL_RUN: if (final_out_valid) next_phase = adapter_pkg::DONE;
            adapter_pkg::DONE:      if (!en)             next_phase = adapter_pkg::IDLE;
            default:                                     next_phase = adapter_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= adapter_pkg::IDLE;
        end else begin
            phase <= next_phase;
        end
    end

    // Scores land on the same edge that enters DONE
    assign capture = (phase == adapter_pkg::FINAL_RUN) && final_out_valid;

    always_ff @(posedge clk) begin
        if (capture) begin
            scores <= final_scores;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scores_valid <= 1'b0;
        end else if (capture) begin
            scores_valid <= 1'b1;
        end else if (next_phase == adapter_pkg::IDLE) begin
            scores_valid <= 1'b0; // Held through DONE, dropped on return to IDLE
        end
    end

    assign acc_fill_en  = (phase == adapter_pkg::ACC_RUN);
    assign acc_drain_en = (phase == adapter_pkg::ACC_DRAIN);
    assign bn_fill_en   = (phase == adapter_pkg::BN_RUN);
    assign bn_drain_en  = (phase == adapter_pkg::BN_DRAIN);

    // Bottleneck stays enabled while it takes input and while it produces
    assign bn_en    = (phase == adapter_pkg::ACC_DRAIN) || (phase == adapter_pkg::BN_RUN);
    assign final_en = (phase == adapter_pkg::BN_DRAIN) || (phase == adapter_pkg::FINAL_RUN);

    assign system_done = (phase == adapter_pkg::DONE);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
    --top-module adapter_tb -o adapter_sim || exit 1
out=$(./obj_dir/adapter_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1

// ==== sources.f ====
+incdir+hdl
hdl/adapter_pkg.sv
hdl/feature_fifo.sv
hdl/channel_feeder.sv
hdl/stage_sequencer.sv
hdl/interface_adapter.sv
tests/adapter_sva.sv
tests/adapter_checker.sv
tests/adapter_tb.sv

// ==== tests/adapter_checker.sv ====
`default_nettype none

`include "adapter_consts.svh"

// Scoreboard for both buffered streams, the score capture and the IDLE outputs
module adapter_checker (
    input  wire logic clk, rst, en, bn_en, final_en,
    input  wire logic acc_valid, acc_ready, bn_out_valid, bn_out_ready,
    input  wire logic bn_in_valid, bn_in_ready, final_in_valid, final_in_ready,
    input  wire logic final_out_valid, scores_valid, system_done,
    input  wire adapter_pkg::word_t       acc_data, bn_out_data,
    input  wire adapter_pkg::bn_beat_t    bn_in_beat,
    input  wire adapter_pkg::final_beat_t final_in_beat,
    input  wire adapter_pkg::class_vec_t  final_scores, scores,
    output int errors, checks, frames
);
    timeunit 1ns;
    timeprecision 100ps;

    adapter_pkg::word_t      acc_q[$];
    adapter_pkg::word_t      bn_q[$];
    adapter_pkg::class_vec_t exp_scores;
    adapter_pkg::word_t      exp_word;
    int                      beat_cnt;   // bn_in beats since reset
    int                      final_cnt;  // final_in beats since reset
    int                      frame_errs;
    logic                    idle;       // Expected IDLE phase
    logic                    done_q;

    task automatic mismatch(input string msg);
        errors++;
        frame_errs++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            acc_q.delete();
            bn_q.delete();
            beat_cnt   = 0;
            final_cnt  = 0;
            errors     = 0;
            checks     = 0;
            frames     = 0;
            frame_errs = 0;
            idle       = 1'b1;
            done_q     = 1'b0;
        end else begin
            if (idle) begin
                checks++;
                if ({acc_ready, bn_in_valid, final_in_valid, bn_en, final_en,
                     system_done, scores_valid} !== 7'b0)
                    mismatch("outputs not all low in IDLE");
            end
            // Bottleneck phases are ACC_DRAIN and BN_RUN
            if (bn_in_valid || bn_out_ready) begin
                checks++;
                if (bn_en !== 1'b1 || final_en !== 1'b0)
                    mismatch("bn_en low or final_en high in a bottleneck phase");
            end
            // Final layer phases are BN_DRAIN and FINAL_RUN
            if (final_in_valid || final_out_valid) begin
                checks++;
                if (final_en !== 1'b1 || bn_en !== 1'b0)
                    mismatch("final_en low or bn_en high in a final layer phase");
            end
            if (acc_valid && acc_ready) acc_q.push_back(acc_data);
            if (bn_out_valid && bn_out_ready) bn_q.push_back(bn_out_data);
            if (bn_in_valid && bn_in_ready) begin
                checks++;
                // Empty queue forces a mismatch
                exp_word = (acc_q.size() > 0) ? acc_q.pop_front() : ~bn_in_beat.data;
                if (bn_in_beat.data !== exp_word
                    || int'(bn_in_beat.channel) != beat_cnt % `BN_IN_CHANNELS)
                    mismatch($sformatf("bn_in %h ch %0d, expected %h ch %0d",
                        bn_in_beat.data, bn_in_beat.channel, exp_word,
                        beat_cnt % `BN_IN_CHANNELS));
                beat_cnt++;
            end
            if (final_in_valid && final_in_ready) begin
                checks++;
                exp_word = (bn_q.size() > 0) ? bn_q.pop_front() : ~final_in_beat.data;
                if (final_in_beat.data !== exp_word
                    || int'(final_in_beat.channel) != final_cnt % `FINAL_IN_CHANNELS)
                    mismatch($sformatf("final_in %h ch %0d, expected %h ch %0d",
                        final_in_beat.data, final_in_beat.channel, exp_word,
                        final_cnt % `FINAL_IN_CHANNELS));
                final_cnt++;
            end
            if (final_out_valid) exp_scores = final_scores;
            if (system_done && !done_q) begin
                checks += 3;
                if (scores !== exp_scores) mismatch("scores differ from the vector sent");
                if (!scores_valid) mismatch("scores_valid low when system_done rose");
                if (acc_q.size() != 0 || bn_q.size() != 0)
                    mismatch($sformatf("words left over, acc %0d bn %0d",
                        acc_q.size(), bn_q.size()));
                frames++;
                $display("Frame %0d finished with %0d errors", frames, frame_errs);
                frame_errs = 0;
            end
            done_q = system_done;
            if (idle && en) idle = 1'b0;
            else if (system_done && !en) idle = 1'b1; // DONE leaves on en low
        end
    end

endmodule

`default_nettype wire

// ==== tests/adapter_sva.sv ====
`default_nettype none

// Phase rules checked inside each stage_sequencer
module adapter_sva (
    input wire logic                clk,
    input wire logic                rst,
    input wire adapter_pkg::phase_t phase,
    input wire logic                bn_en,
    input wire logic                final_en,
    input wire logic                scores_valid,
    input wire logic                system_done
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0; // Summed into the testbench totals

    // Phase moves one step forward or from DONE back to IDLE
    phase_steps: assert property (@(posedge clk) disable iff (rst)
        (phase != $past(phase)) |-> ((3'(phase) == 3'($past(phase)) + 3'd1)
            || (phase == adapter_pkg::IDLE && $past(phase) == adapter_pkg::DONE)))
    else begin
        $error("Sequencer phase skipped a state");
        fail_count++;
    end

    enables_apart: assert property (@(posedge clk) disable iff (rst)
        (bn_en && final_en) |-> (phase == adapter_pkg::BN_DRAIN))
    else begin
        $error("bn_en and final_en both high outside BN_DRAIN");
        fail_count++;
    end

    // DONE is only reached through a score capture
    done_in_done: assert property (@(posedge clk) disable iff (rst)
        system_done |-> (phase == adapter_pkg::DONE) && scores_valid)
    else begin
        $error("system_done high outside DONE or without captured scores");
        fail_count++;
    end

endmodule

bind stage_sequencer adapter_sva sva0 (
    .clk, .rst, .phase, .bn_en, .final_en, .scores_valid, .system_done
);

`default_nettype wire

// ==== tests/adapter_tb.sv ====
`default_nettype none

`include "adapter_consts.svh"

module adapter_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAMES  = 4;
    localparam int MAX_ACC = 40;  // Below the acc FIFO depth since nothing drains during the fill
    localparam int MAX_BN  = 30;
    // Two streams per word and up to 4x for ready gaps
    localparam int CYCLE_LIMIT = FRAMES * (MAX_ACC + MAX_BN) * 2 * 4 + 400;
    localparam logic [31:0] SEED = 32'h9b26_4eb6;

    logic clk, rst, en, acc_done, bn_done, bn_en, final_en;
    logic acc_valid, acc_ready, bn_out_valid, bn_out_ready;
    logic bn_in_valid, bn_in_ready, final_in_valid, final_in_ready;
    logic final_out_valid, scores_valid, system_done;
    adapter_pkg::word_t       acc_data, bn_out_data;
    adapter_pkg::bn_beat_t    bn_in_beat;
    adapter_pkg::final_beat_t final_in_beat;
    adapter_pkg::class_vec_t  final_scores, scores;
    logic [31:0]              main_rng;
    logic [31:0]              ready_rng;
    int                       cycles, errors, checks, frames, total_errors;

    interface_adapter dut0 (.*);
    adapter_checker chk0 (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic adapter_pkg::word_t draw_word();
        main_rng = lcg_next(main_rng);
        return main_rng[31:16];
    endfunction

    function automatic int draw_count(input int max);
        main_rng = lcg_next(main_rng);
        return 1 + int'(main_rng[31:16]) % max;
    endfunction

    // First layer words followed by the acc_done pulse
    task automatic send_acc_words(input int n);
        for (int i = 0; i < n; i++) begin
            acc_valid <= 1'b1;
            acc_data  <= draw_word();
            @(posedge clk);
            while (!acc_ready) @(posedge clk);
        end
        acc_valid <= 1'b0;
        acc_done  <= 1'b1;
        @(posedge clk);
        acc_done <= 1'b0;
    endtask

    // Bottleneck words wait until BN_RUN opens the FIFO
    task automatic send_bn_words(input int n);
        for (int i = 0; i < n; i++) begin
            bn_out_valid <= 1'b1;
            bn_out_data  <= draw_word();
            @(posedge clk);
            while (!bn_out_ready) @(posedge clk);
        end
        bn_out_valid <= 1'b0;
        bn_done      <= 1'b1;
        @(posedge clk);
        bn_done <= 1'b0;
    endtask

    task automatic finish_final_layer(input int n);
        adapter_pkg::class_vec_t vec;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            while (!(final_in_valid && final_in_ready)) @(posedge clk);
        end
        @(posedge clk); // Drained flag moves the phase to FINAL_RUN
        for (int k = 0; k < `NUM_CLASSES; k++) vec[k] = draw_word();
        final_out_valid <= 1'b1;
        final_scores    <= vec;
        @(posedge clk);
        final_out_valid <= 1'b0;
        while (!system_done) @(posedge clk);
    endtask

    task automatic run_frame();
        int n_acc;
        int n_bn;
        n_acc = draw_count(MAX_ACC);
        n_bn  = draw_count(MAX_BN);
        en <= 1'b1;
        send_acc_words(n_acc);
        send_bn_words(n_bn);
        finish_final_layer(n_bn);
        en <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Each ready drops about one cycle in four
    initial begin
        bn_in_ready    = 1'b0;
        final_in_ready = 1'b0;
        ready_rng      = ~SEED;
        forever begin
            @(posedge clk);
            ready_rng = lcg_next(ready_rng);
            bn_in_ready    <= (ready_rng[31:30] != 2'b00);
            final_in_ready <= (ready_rng[29:28] != 2'b00);
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the DUT did not finish %0d frames in %0d cycles", FRAMES, CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        main_rng        = SEED;
        rst             = 1'b1;
        en              = 1'b0;
        acc_valid       = 1'b0;
        acc_data        = '0;
        acc_done        = 1'b0;
        bn_out_valid    = 1'b0;
        bn_out_data     = '0;
        bn_done         = 1'b0;
        final_out_valid = 1'b0;
        final_scores    = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        for (int f = 0; f < FRAMES; f++) run_frame();
        @(negedge clk);
        total_errors = errors + dut0.seq.sva0.fail_count;
        $display("Totals: %0d frames, %0d checks, %0d errors", frames, checks, total_errors);
        if (total_errors == 0 && frames == FRAMES) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
